/* src/ddc_pkg.sv */
/*
 * DDC shared definitions: sample and accumulator widths, settings
 * register map, rotation quadrants and output buffer sizing
 */
package ddc_pkg;

  localparam int SAMPLE_WIDTH = 16;
  localparam int MIX_WIDTH    = SAMPLE_WIDTH + 1;  // room to negate the most negative sample
  localparam int MAX_DECIM    = 16;

  // smallest n with 2**n >= value
  function automatic int log2_ceil(input int value);
    int result = 0;
    while ((1 << result) < value) begin
      result++;
    end
    return result;
  endfunction

  // bit growth of a 4-stage CIC is 4 * log2(rate)
  localparam int CIC_WIDTH    = MIX_WIDTH + 4 * log2_ceil(MAX_DECIM);
  localparam int SCALE_WIDTH  = 18;
  localparam int SCALE_SHIFT  = 16;                // 2**16 is unity gain
  localparam int PHASE_WIDTH  = 32;
  localparam int FIFO_DEPTH   = 16;
  localparam int PIPE_RESERVE = 8;                 // slots kept free for samples in flight

  typedef enum logic [7:0] {
    REG_FREQ  = 8'd0,
    REG_SCALE = 8'd1,
    REG_DECIM = 8'd2,
    REG_MUX   = 8'd3
  } ddc_reg_e;

  typedef enum logic [1:0] {
    QUAD_0   = 2'd0,
    QUAD_90  = 2'd1,
    QUAD_180 = 2'd2,
    QUAD_270 = 2'd3
  } quad_e;

endpackage

/* src/ddc_settings.sv */
/*
 * DDC settings registers. Holds frequency, scale and mux settings and
 * defers a decimation rate change until the chain is idle or cleared
 */
module ddc_settings (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   i_clear,
  input  logic                                   i_set_stb,
  input  logic [7:0]                             i_set_addr,
  input  logic [31:0]                            i_set_data,
  input  logic                                   i_in_fire,
  output logic [ddc_pkg::PHASE_WIDTH-1:0]        o_phase_inc,
  output logic signed [ddc_pkg::SCALE_WIDTH-1:0] o_scale,
  output logic [7:0]                             o_decim_rate,
  output logic                                   o_rate_stb,
  output logic                                   o_realmode,
  output logic                                   o_swap_iq
);
  import ddc_pkg::*;

  logic       active;     // samples entered since the last clear
  logic       rate_wr;
  logic       rate_pend;  // rate write waiting for a clear
  logic [7:0] rate_req;

  assign rate_wr = i_set_stb & (i_set_addr == REG_DECIM);

  always_ff @(posedge clk) begin
    if (reset) begin
      o_phase_inc <= '0;
      o_scale     <= SCALE_WIDTH'(1 << SCALE_SHIFT);  // unity gain
      o_realmode  <= 1'b0;
      o_swap_iq   <= 1'b0;
    end else if (i_set_stb) begin
      case (ddc_reg_e'(i_set_addr))
        REG_FREQ:  o_phase_inc <= i_set_data[PHASE_WIDTH-1:0];
        REG_SCALE: o_scale     <= i_set_data[SCALE_WIDTH-1:0];
        REG_MUX: begin
          o_realmode <= i_set_data[1];
          o_swap_iq  <= i_set_data[0];
        end
        default: ;  // rate handled below, others ignored
      endcase
    end
  end

  // changing the rate mid-stream would corrupt the CIC output
  always_ff @(posedge clk) begin
    if (reset) begin
      active       <= 1'b0;
      rate_pend    <= 1'b0;
      o_decim_rate <= 8'd1;
      o_rate_stb   <= 1'b0;
    end else begin
      o_rate_stb <= 1'b0;
      if (i_clear) begin
        active <= 1'b0;
      end else if (i_in_fire) begin
        active <= 1'b1;
      end
      if (rate_wr & (i_clear | ~active)) begin
        o_decim_rate <= i_set_data[7:0];  // idle, apply at once
        o_rate_stb   <= 1'b1;
        rate_pend    <= 1'b0;
      end else if (rate_pend & i_clear) begin
        o_decim_rate <= rate_req;
        o_rate_stb   <= 1'b1;
        rate_pend    <= 1'b0;
      end else if (rate_wr) begin
        rate_pend <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rate_wr) begin
      rate_req <= i_set_data[7:0];
    end
  end

endmodule

/* src/ddc_mixer.sv */
/*
 * DDC mixer. I/Q swap and real-mode mux, phase accumulator and a
 * quarter-turn rotation picked by the top two phase bits
 */
module ddc_mixer (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 i_clear,
  input  logic                                 i_fire,
  input  logic [2*ddc_pkg::SAMPLE_WIDTH-1:0]   i_data,
  input  logic [ddc_pkg::PHASE_WIDTH-1:0]      i_phase_inc,
  input  logic                                 i_realmode,
  input  logic                                 i_swap_iq,
  output logic                                 o_stb,
  output logic signed [ddc_pkg::MIX_WIDTH-1:0] o_i,
  output logic signed [ddc_pkg::MIX_WIDTH-1:0] o_q
);
  import ddc_pkg::*;

  logic [PHASE_WIDTH-1:0]         phase;
  quad_e                          quad;
  logic signed [SAMPLE_WIDTH-1:0] in_i;
  logic signed [SAMPLE_WIDTH-1:0] in_q;
  logic signed [MIX_WIDTH-1:0]    ext_i;  // sign-extended mux output
  logic signed [MIX_WIDTH-1:0]    ext_q;
  logic signed [MIX_WIDTH-1:0]    rot_i;
  logic signed [MIX_WIDTH-1:0]    rot_q;

  assign in_i  = i_data[2*SAMPLE_WIDTH-1:SAMPLE_WIDTH];  // I in upper half
  assign in_q  = i_data[SAMPLE_WIDTH-1:0];
  assign ext_i = i_swap_iq ? in_q : in_i;
  assign ext_q = i_realmode ? MIX_WIDTH'(0) : (i_swap_iq ? in_i : in_q);
  assign quad  = quad_e'(phase[PHASE_WIDTH-1 -: 2]);

  always_comb begin
    case (quad)
      QUAD_0: begin
        rot_i = ext_i;
        rot_q = ext_q;
      end
      QUAD_90: begin
        rot_i = ext_q;
        rot_q = -ext_i;
      end
      QUAD_180: begin
        rot_i = -ext_i;
        rot_q = -ext_q;
      end
      default: begin
        rot_i = -ext_q;
        rot_q = ext_i;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset | i_clear) begin
      phase <= '0;
      o_stb <= 1'b0;
    end else begin
      o_stb <= i_fire;
      if (i_fire) begin
        phase <= phase + i_phase_inc;  // next sample uses the advanced phase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_fire) begin
      o_i <= rot_i;
      o_q <= rot_q;
    end
  end

endmodule

/* src/cic_decimate.sv */
/*
 * Four-stage CIC decimator for an I/Q pair. Integrators run on every
 * input strobe, combs on every rate-th one. Output is the unscaled sum
 */
module cic_decimate #(
  parameter int MAX_RATE = ddc_pkg::MAX_DECIM
) (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 i_clear,
  input  logic                                 i_rate_stb,
  input  logic [7:0]                           i_rate,
  input  logic                                 i_stb,
  input  logic signed [ddc_pkg::MIX_WIDTH-1:0] i_i,
  input  logic signed [ddc_pkg::MIX_WIDTH-1:0] i_q,
  output logic                                 o_stb,
  output logic signed [ddc_pkg::CIC_WIDTH-1:0] o_i,
  output logic signed [ddc_pkg::CIC_WIDTH-1:0] o_q
);
  import ddc_pkg::*;

  localparam int N     = 4;
  localparam int CNT_W = $clog2(MAX_RATE + 1);

  logic                        restart;
  logic [CNT_W-1:0]            rate_eff;
  logic [CNT_W-1:0]            cnt;
  logic                        hit;
  logic                        dec_stb;  // int4 holds a sample to decimate
  logic signed [CIC_WIDTH-1:0] x_in      [2];
  logic signed [CIC_WIDTH-1:0] integ     [2][N];
  logic signed [CIC_WIDTH-1:0] integ_nxt [2][N];
  logic signed [CIC_WIDTH-1:0] comb_in   [2][N];
  logic signed [CIC_WIDTH-1:0] comb_dly  [2][N];
  logic signed [CIC_WIDTH-1:0] comb_out  [2];

  assign restart = reset | i_clear | i_rate_stb;
  assign x_in[0] = i_i;
  assign x_in[1] = i_q;

  // rate 0 behaves as 1, anything above MAX_RATE is clamped
  always_comb begin
    if (i_rate == 8'd0) begin
      rate_eff = CNT_W'(1);
    end else if (int'(i_rate) > MAX_RATE) begin
      rate_eff = CNT_W'(MAX_RATE);
    end else begin
      rate_eff = CNT_W'(i_rate);
    end
  end

  assign hit = (cnt == rate_eff - 1'b1);

  always_comb begin
    for (int c = 0; c < 2; c++) begin
      integ_nxt[c][0] = integ[c][0] + x_in[c];
      for (int k = 1; k < N; k++) begin
        integ_nxt[c][k] = integ[c][k] + integ_nxt[c][k-1];
      end
    end
  end

  // differential delay of 1 in the decimated domain
  always_comb begin
    for (int c = 0; c < 2; c++) begin
      comb_in[c][0] = integ[c][N-1];
      for (int k = 1; k < N; k++) begin
        comb_in[c][k] = comb_in[c][k-1] - comb_dly[c][k-1];
      end
      comb_out[c] = comb_in[c][N-1] - comb_dly[c][N-1];
    end
  end

  always_ff @(posedge clk) begin
    if (restart) begin
      cnt      <= '0;
      dec_stb  <= 1'b0;
      o_stb    <= 1'b0;
      integ    <= '{default: '0};
      comb_dly <= '{default: '0};
    end else begin
      dec_stb <= i_stb & hit;
      o_stb   <= dec_stb;
      if (i_stb) begin
        cnt   <= hit ? '0 : cnt + 1'b1;
        integ <= integ_nxt;
      end
      if (dec_stb) begin
        comb_dly <= comb_in;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (dec_stb) begin
      o_i <= comb_out[0];
      o_q <= comb_out[1];
    end
  end

endmodule

/* src/ddc_scale_round.sv */
/*
 * Output scaler. Signed multiply with half-LSB offset, arithmetic
 * shift, then saturation to 16 bits and I/Q packing
 */
module ddc_scale_round (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   i_clear,
  input  logic signed [ddc_pkg::SCALE_WIDTH-1:0] i_scale,
  input  logic                                   i_stb,
  input  logic signed [ddc_pkg::CIC_WIDTH-1:0]   i_i,
  input  logic signed [ddc_pkg::CIC_WIDTH-1:0]   i_q,
  output logic                                   o_stb,
  output logic [2*ddc_pkg::SAMPLE_WIDTH-1:0]     o_data
);
  import ddc_pkg::*;

  localparam int PROD_W  = CIC_WIDTH + SCALE_WIDTH;
  localparam int SHIFT_W = PROD_W - SCALE_SHIFT;
  localparam logic signed [PROD_W-1:0]  HALF    = 1 <<< (SCALE_SHIFT - 1);
  localparam logic signed [SHIFT_W-1:0] SAT_MAX = (1 <<< (SAMPLE_WIDTH - 1)) - 1;
  localparam logic signed [SHIFT_W-1:0] SAT_MIN = -(1 <<< (SAMPLE_WIDTH - 1));

  logic [2:0]                     stb_pipe;  // multiply, round, clip
  logic signed [CIC_WIDTH-1:0]    x_in    [2];
  logic signed [PROD_W-1:0]       prod    [2];
  logic signed [SHIFT_W-1:0]      shifted [2];
  logic signed [SAMPLE_WIDTH-1:0] sat     [2];

  assign x_in[0] = i_i;
  assign x_in[1] = i_q;
  assign o_stb   = stb_pipe[2];
  assign o_data  = {sat[0], sat[1]};  // I upper, Q lower

  always_ff @(posedge clk) begin
    if (reset | i_clear) begin
      stb_pipe <= '0;
    end else begin
      stb_pipe <= {stb_pipe[1:0], i_stb};
    end
  end

  always_ff @(posedge clk) begin
    for (int c = 0; c < 2; c++) begin
      if (i_stb) begin
        prod[c] <= x_in[c] * i_scale + HALF;
      end
      if (stb_pipe[0]) begin
        shifted[c] <= SHIFT_W'(prod[c] >>> SCALE_SHIFT);
      end
      if (stb_pipe[1]) begin
        if (shifted[c] > SAT_MAX) begin
          sat[c] <= SAT_MAX[SAMPLE_WIDTH-1:0];
        end else if (shifted[c] < SAT_MIN) begin
          sat[c] <= SAT_MIN[SAMPLE_WIDTH-1:0];
        end else begin
          sat[c] <= shifted[c][SAMPLE_WIDTH-1:0];
        end
      end
    end
  end

endmodule

/* src/sample_fifo.sv */
/*
 * Output sample buffer. Circular buffer with valid/ready read side
 * and a free-entry count for input flow control
 */
module sample_fifo #(
  parameter int DEPTH = ddc_pkg::FIFO_DEPTH
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               i_clear,
  input  logic                               i_push,
  input  logic [2*ddc_pkg::SAMPLE_WIDTH-1:0] i_data,
  output logic                               o_valid,
  output logic [2*ddc_pkg::SAMPLE_WIDTH-1:0] o_data,
  input  logic                               i_ready,
  output logic [$clog2(DEPTH+1)-1:0]         o_free
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [2*ddc_pkg::SAMPLE_WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0]                   wr_ptr;
  logic [PTR_W-1:0]                   rd_ptr;
  logic [CNT_W-1:0]                   count;
  logic                               full;
  logic                               pop;
  logic                               push_ok;

  assign full    = (count == CNT_W'(DEPTH));
  assign pop     = o_valid & i_ready;
  assign push_ok = i_push & (~full | pop);  // a word leaving frees its slot
  assign o_valid = (count != '0);
  assign o_data  = mem[rd_ptr];
  assign o_free  = CNT_W'(DEPTH) - count;

  always_ff @(posedge clk) begin
    if (reset | i_clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push_ok, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= i_data;
    end
  end

endmodule

/* src/ddc.sv */
/*
 * Digital down-converter top level. Mixer, CIC decimator and scaler
 * feed an output buffer; input is stalled when the buffer runs low
 */
module ddc #(
  parameter int MAX_DECIM  = ddc_pkg::MAX_DECIM,
  parameter int FIFO_DEPTH = ddc_pkg::FIFO_DEPTH
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               i_clear,      // datapath only, settings kept
  input  logic                               i_set_stb,
  input  logic [7:0]                         i_set_addr,
  input  logic [31:0]                        i_set_data,
  input  logic                               i_in_valid,
  input  logic [2*ddc_pkg::SAMPLE_WIDTH-1:0] i_in_data,
  output logic                               o_in_ready,
  output logic                               o_out_valid,
  output logic [2*ddc_pkg::SAMPLE_WIDTH-1:0] o_out_data,
  input  logic                               i_out_ready
);
  import ddc_pkg::*;

  logic                           in_fire;
  logic [PHASE_WIDTH-1:0]         phase_inc;
  logic signed [SCALE_WIDTH-1:0]  scale;
  logic [7:0]                     decim_rate;
  logic                           rate_stb;
  logic                           realmode;
  logic                           swap_iq;
  logic                           mix_stb;
  logic signed [MIX_WIDTH-1:0]    mix_i;
  logic signed [MIX_WIDTH-1:0]    mix_q;
  logic                           cic_stb;
  logic signed [CIC_WIDTH-1:0]    cic_i;
  logic signed [CIC_WIDTH-1:0]    cic_q;
  logic                           push;
  logic [2*SAMPLE_WIDTH-1:0]      push_data;
  logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_free;

  assign in_fire    = i_in_valid & o_in_ready;
  assign o_in_ready = int'(fifo_free) > PIPE_RESERVE;  // reserve absorbs the pipeline

  ddc_settings u_settings (
    .clk, .reset, .i_clear, .i_set_stb, .i_set_addr, .i_set_data,
    .i_in_fire(in_fire), .o_phase_inc(phase_inc), .o_scale(scale),
    .o_decim_rate(decim_rate), .o_rate_stb(rate_stb),
    .o_realmode(realmode), .o_swap_iq(swap_iq));

  ddc_mixer u_mixer (
    .clk, .reset, .i_clear, .i_fire(in_fire), .i_data(i_in_data),
    .i_phase_inc(phase_inc), .i_realmode(realmode), .i_swap_iq(swap_iq),
    .o_stb(mix_stb), .o_i(mix_i), .o_q(mix_q));

  cic_decimate #(.MAX_RATE(MAX_DECIM)) u_cic (
    .clk, .reset, .i_clear, .i_rate_stb(rate_stb), .i_rate(decim_rate),
    .i_stb(mix_stb), .i_i(mix_i), .i_q(mix_q),
    .o_stb(cic_stb), .o_i(cic_i), .o_q(cic_q));

  ddc_scale_round u_scale (
    .clk, .reset, .i_clear, .i_scale(scale), .i_stb(cic_stb),
    .i_i(cic_i), .i_q(cic_q), .o_stb(push), .o_data(push_data));

  sample_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo (
    .clk, .reset, .i_clear, .i_push(push), .i_data(push_data),
    .o_valid(o_out_valid), .o_data(o_out_data), .i_ready(i_out_ready),
    .o_free(fifo_free));

endmodule

/* tb/ddc_chk.sv */
/*
 * DDC protocol checks bound onto the top level. Buffer overflow,
 * output hold under back-pressure and output state after reset
 */
module ddc_chk #(
  parameter int FREE_W = 5
) (
  input logic              clk,
  input logic              reset,
  input logic              i_clear,
  input logic              i_push,
  input logic [FREE_W-1:0] i_free,
  input logic              i_out_valid,
  input logic              i_out_ready,
  input logic [31:0]       i_out_data
);

  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    i_push |-> (i_free != '0))
    else $error("output buffer pushed while full");

  // a stalled word stays put until taken
  a_hold_data: assert property (@(posedge clk) disable iff (reset)
    (i_out_valid && !i_out_ready && !i_clear) |=> (i_out_valid && $stable(i_out_data)))
    else $error("output word changed while stalled");

  a_reset_idle: assert property (@(posedge clk)
    reset |=> !i_out_valid)
    else $error("output valid high after reset");

endmodule

/* tb/ddc_model.svh */
/*
 * Behavioral model of the DDC datapath. Tracks settings, mux, rotation,
 * CIC and scaler rules and queues the expected output words
 */
`ifndef DDC_MODEL_SVH
`define DDC_MODEL_SVH

localparam longint SAT_HI = 2 ** (SAMPLE_WIDTH - 1) - 1;
localparam longint SAT_LO = -(2 ** (SAMPLE_WIDTH - 1));

logic [2*SAMPLE_WIDTH-1:0] exp_q [$];
logic [PHASE_WIDTH-1:0]    m_phase;
logic [PHASE_WIDTH-1:0]    m_inc;
longint                    m_scale;
int                        m_rate;
int                        m_rate_req;  // rate held back while active
bit                        m_pend;
bit                        m_active;
bit                        m_real;
bit                        m_swap;
int                        m_cnt;
longint                    m_integ [2][4];
longint                    m_dly   [2][4];

function automatic void zero_cic();
  m_cnt = 0;
  for (int c = 0; c < 2; c++) begin
    for (int k = 0; k < 4; k++) begin
      m_integ[c][k] = 0;
      m_dly[c][k]   = 0;
    end
  end
endfunction

function automatic void init_model();
  m_phase  = '0;
  m_inc    = '0;
  m_scale  = 65536;  // unity
  m_rate   = 1;
  m_pend   = 1'b0;
  m_active = 1'b0;
  m_real   = 1'b0;
  m_swap   = 1'b0;
  zero_cic();
  exp_q.delete();
endfunction

// round half up, arithmetic shift, then clip to the sample range
function automatic longint scale_round(input longint v);
  longint y;
  y = (v * m_scale + (longint'(1) << (SCALE_SHIFT - 1))) >>> SCALE_SHIFT;
  if (y > SAT_HI) begin
    y = SAT_HI;
  end else if (y < SAT_LO) begin
    y = SAT_LO;
  end
  return y;
endfunction

function automatic void accept_sample(input logic [2*SAMPLE_WIDTH-1:0] word);
  longint s_i;
  longint s_q;
  longint e_i;
  longint e_q;
  longint x [2];
  longint y [2];
  longint v;
  longint t;
  s_i = $signed(word[2*SAMPLE_WIDTH-1:SAMPLE_WIDTH]);
  s_q = $signed(word[SAMPLE_WIDTH-1:0]);
  e_i = m_swap ? s_q : s_i;
  e_q = m_real ? 0 : (m_swap ? s_i : s_q);
  case (quad_e'(m_phase[PHASE_WIDTH-1 -: 2]))
    QUAD_0: begin
      x[0] = e_i;
      x[1] = e_q;
    end
    QUAD_90: begin
      x[0] = e_q;
      x[1] = -e_i;
    end
    QUAD_180: begin
      x[0] = -e_i;
      x[1] = -e_q;
    end
    default: begin
      x[0] = -e_q;
      x[1] = e_i;
    end
  endcase
  m_phase  = m_phase + m_inc;
  m_active = 1'b1;
  for (int c = 0; c < 2; c++) begin
    m_integ[c][0] += x[c];
    for (int k = 1; k < 4; k++) begin
      m_integ[c][k] += m_integ[c][k-1];
    end
  end
  m_cnt++;
  if (m_cnt == m_rate) begin
    m_cnt = 0;
    for (int c = 0; c < 2; c++) begin
      v = m_integ[c][3];
      for (int k = 0; k < 4; k++) begin
        t           = v - m_dly[c][k];  // comb, delay of one decimated sample
        m_dly[c][k] = v;
        v           = t;
      end
      y[c] = scale_round(v);
    end
    exp_q.push_back({16'(y[0]), 16'(y[1])});
  end
endfunction

function automatic void write_setting(input ddc_reg_e addr, input logic [31:0] data);
  case (addr)
    REG_FREQ:  m_inc = data;
    REG_SCALE: m_scale = $signed(data[SCALE_WIDTH-1:0]);
    REG_DECIM: begin
      if (m_active) begin
        m_rate_req = data[7:0];
        m_pend     = 1'b1;
      end else begin
        m_rate = data[7:0];
        m_pend = 1'b0;
        zero_cic();
      end
    end
    REG_MUX: begin
      m_real = data[1];
      m_swap = data[0];
    end
    default: ;
  endcase
endfunction

function automatic void clear_model();
  m_phase  = '0;
  m_active = 1'b0;
  zero_cic();
  if (m_pend) begin
    m_rate = m_rate_req;  // deferred rate takes effect here
    m_pend = 1'b0;
  end
endfunction

`endif

/* tb/ddc_tb.sv */
/*
 * DDC testbench. Random samples and settings from a fixed seed, every
 * output word compared with a behavioral model of the datapath
 */
module ddc_tb;
  import ddc_pkg::*;

  localparam int CLK_PERIOD    = 4;
  localparam int SEED          = 41215;
  localparam int N_PASS        = 40;
  localparam int N_MUX         = 30;   // per mux mode, three modes
  localparam int N_ROT         = 40;
  localparam int N_DEC_ROUNDS  = 6;
  localparam int N_DEC         = 120;
  localparam int N_BP_ROUNDS   = 3;
  localparam int N_BP          = 90;   // 20 + 30 before the clear, 40 after
  localparam int TOTAL_SAMPLES = N_PASS + 3 * N_MUX + N_ROT + N_DEC_ROUNDS * N_DEC
                                 + N_BP_ROUNDS * N_BP;
  localparam int TIMEOUT       = (TOTAL_SAMPLES * MAX_DECIM + 2000) * CLK_PERIOD;

  logic                      clk;
  logic                      reset;
  logic                      i_clear;
  logic                      i_set_stb;
  logic [7:0]                i_set_addr;
  logic [31:0]               i_set_data;
  logic                      i_in_valid;
  logic [2*SAMPLE_WIDTH-1:0] i_in_data;
  logic                      o_in_ready;
  logic                      o_out_valid;
  logic [2*SAMPLE_WIDTH-1:0] o_out_data;
  logic                      i_out_ready;
  logic                      bp_en;  // random output stalls
  string                     test_name;
  logic [2*SAMPLE_WIDTH-1:0] exp_word;
  int                        rate1;
  int                        rate2;

  `include "ddc_model.svh"

  ddc #(.MAX_DECIM(MAX_DECIM), .FIFO_DEPTH(FIFO_DEPTH)) i_dut (
    .clk, .reset, .i_clear, .i_set_stb, .i_set_addr, .i_set_data,
    .i_in_valid, .i_in_data, .o_in_ready,
    .o_out_valid, .o_out_data, .i_out_ready);

  bind ddc ddc_chk #(.FREE_W($clog2(FIFO_DEPTH + 1))) u_chk (
    .clk, .reset, .i_clear, .i_push(push), .i_free(fifo_free),
    .i_out_valid(o_out_valid), .i_out_ready, .i_out_data(o_out_data));

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  initial begin
    #(TIMEOUT);
    fail_run($sformatf("timeout in test %s, outputs stopped arriving", test_name));
  end

  initial begin
    i_out_ready = 1'b1;
    forever begin
      @(posedge clk);
      i_out_ready <= bp_en ? ($urandom_range(3) == 0) : 1'b1;
    end
  end

  // accepted inputs feed the model, leaving words are checked against it
  always @(posedge clk) begin
    if (!reset) begin
      // words still owed bound the buffer fill from above
      if (exp_q.size() < FIFO_DEPTH - PIPE_RESERVE) begin
        assert (o_in_ready)
          else fail_run($sformatf("mismatch in %s: o_in_ready expected 1, actual %b",
                                  test_name, o_in_ready));
      end
      if (i_in_valid && o_in_ready) begin
        accept_sample(i_in_data);
      end
      if (o_out_valid && i_out_ready) begin
        assert (exp_q.size() != 0)
          else fail_run($sformatf("unexpected output word %h in test %s", o_out_data,
                                  test_name));
        if (exp_q.size() != 0) begin
          exp_word = exp_q.pop_front();
          assert (o_out_data == exp_word)
            else fail_run($sformatf("mismatch in %s: expected %h, actual %h", test_name,
                                    exp_word, o_out_data));
        end
      end
    end
  end

  function automatic logic [31:0] rand_sample();
    logic [31:0] w;
    w = $urandom;
    case ($urandom_range(7))
      0: w[31:16] = 16'h8000;  // most negative, overflows on negation
      1: w[15:0] = 16'h8000;
      2: w = 32'h7fff_7fff;
      default: ;
    endcase
    return w;
  endfunction

  function automatic logic [17:0] rand_scale();
    case ($urandom_range(3))
      0: return 18'($urandom);
      1: return 18'h1_0000;
      2: return 18'h1_ffff;  // forces clipping
      default: return 18'(1 << $urandom_range(12, 8));
    endcase
  endfunction

  task automatic write_reg(input ddc_reg_e addr, input logic [31:0] data);
    i_set_stb  <= 1'b1;
    i_set_addr <= addr;
    i_set_data <= data;
    @(posedge clk);
    i_set_stb <= 1'b0;
    write_setting(addr, data);
    repeat (2) @(posedge clk);
  endtask

  task automatic pulse_clear();
    i_clear <= 1'b1;
    @(posedge clk);
    i_clear <= 1'b0;
    clear_model();
    repeat (2) @(posedge clk);
  endtask

  // holds each sample until the DUT takes it, with random gaps
  task automatic send_samples(input int n);
    int sent;
    sent = 0;
    while (sent < n) begin
      if ($urandom_range(3) == 0) begin
        i_in_valid <= 1'b0;
        @(posedge clk);
      end else begin
        i_in_valid <= 1'b1;
        i_in_data  <= rand_sample();
        do @(posedge clk); while (!o_in_ready);
        sent++;
      end
    end
    i_in_valid <= 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) @(posedge clk);
    repeat (12) @(posedge clk);
  endtask

  initial begin
    void'($urandom(SEED));
    reset      = 1'b1;
    i_clear    = 1'b0;
    i_set_stb  = 1'b0;
    i_set_addr = '0;
    i_set_data = '0;
    i_in_valid = 1'b0;
    i_in_data  = '0;
    bp_en      = 1'b0;
    test_name  = "reset";
    init_model();
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    test_name = "passthrough";  // reset defaults
    send_samples(N_PASS);
    drain();

    test_name = "mux";
    for (int m = 1; m <= 3; m++) begin
      pulse_clear();
      write_reg(REG_MUX, 32'(m));
      send_samples(N_MUX);
      drain();
    end
    write_reg(REG_MUX, 32'd0);

    test_name = "rotation";
    pulse_clear();
    write_reg(REG_FREQ, 32'h4000_0000);  // quarter turn per sample
    send_samples(N_ROT);
    drain();

    test_name = "decimation";
    for (int r = 0; r < N_DEC_ROUNDS; r++) begin
      pulse_clear();
      write_reg(REG_DECIM, $urandom_range(16, 1));
      write_reg(REG_SCALE, 32'(rand_scale()));
      write_reg(REG_FREQ, $urandom);
      send_samples(N_DEC);
      drain();
    end

    test_name = "backpressure";
    bp_en <= 1'b1;
    for (int r = 0; r < N_BP_ROUNDS; r++) begin
      rate1 = (r == 0) ? 1 : $urandom_range(16, 1);  // rate 1 fills the buffer
      rate2 = (rate1 + $urandom_range(14, 1)) % 16 + 1;  // never equal to rate1
      pulse_clear();
      write_reg(REG_DECIM, rate1);
      write_reg(REG_SCALE, 32'(rand_scale()));
      write_reg(REG_FREQ, $urandom);
      send_samples(20);
      write_reg(REG_DECIM, rate2);  // chain active, held until clear
      send_samples(30);
      drain();
      pulse_clear();
      send_samples(40);
      drain();
    end
    bp_en <= 1'b0;

    test_name = "end of run";
    if (exp_q.size() == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      fail_run($sformatf("%0d expected words never left the DUT", exp_q.size()));
    end
  end

endmodule

/* ddc.f */
+incdir+tb
src/ddc_pkg.sv
src/ddc_settings.sv
src/ddc_mixer.sv
src/cic_decimate.sv
src/ddc_scale_round.sv
src/sample_fifo.sv
src/ddc.sv
tb/ddc_chk.sv
tb/ddc_tb.sv

/* Makefile */
# Verilator build and run for the DDC testbench

TOP   := ddc_tb
BUILD := obj_dir
LOG   := sim.log

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): ddc.f $(wildcard src/*.sv) $(wildcard tb/*.sv) $(wildcard tb/*.svh)
	verilator --binary --assert -Wno-fatal -f ddc.f --top-module $(TOP) -Mdir $(BUILD)

run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

lint:
	verilator --lint-only -Wall -f ddc.f --top-module $(TOP)

clean:
	rm -rf $(BUILD) $(LOG)
